/* cnn_pkg.sv */
package cnn_pkg;

	// --------------------------------------------------------------------
	// Sizes
	// --------------------------------------------------------------------
	localparam int PIX_BITS      = 8;
	localparam int WGT_BITS      = 8;			// Signed kernel weight
	localparam int W_SIZE        = 12;			// Up to 4K lines
	localparam int W_DELAY       = 12;
	localparam int N_TAPS        = 9;			// 3x3 window
	localparam int N_KERN        = 4;			// Output channels in parallel
	localparam int PARAM_BITS    = 16;			// Scale and bias
	localparam int ACC_BITS      = 20;			// 9 x (u8 * s8) with sign
	localparam int AHB_ADDR_BITS = 32;
	localparam int AHB_DATA_BITS = 32;

	// Address map
	localparam int REG_IDX_LSB   = 2;			// Word aligned registers
	localparam int IMG_SEL_BIT   = 12;			// Image buffer window
	localparam int REG_IDX_BITS  = IMG_SEL_BIT - REG_IDX_LSB;

	localparam logic HRESP_OKAY  = 1'b0;

	// --------------------------------------------------------------------
	// Enums
	// --------------------------------------------------------------------
	typedef enum logic [REG_IDX_BITS-1:0] {
		REG_WIDTH_HEIGHT,	// 0
		REG_DELAYS,			// 1
		REG_LAYER_CFG,		// 2
		REG_START,			// 3
		REG_DONE			// 4
	} reg_idx_e;

	typedef enum logic [1:0] {IDLE, BUSY, NONSEQ, SEQ} htrans_e;

	typedef enum logic {ACT_RELU, ACT_LINEAR} act_type_e;

	typedef enum logic [1:0] {SCAN_IDLE, SCAN_STARTUP, SCAN_ROW, SCAN_HSYNC} scan_state_e;

	// --------------------------------------------------------------------
	// Structs
	// --------------------------------------------------------------------
	typedef struct packed {
		logic [W_SIZE-1:0]  width;
		logic [W_SIZE-1:0]  height;
		logic [W_DELAY-1:0] start_up_delay;
		logic [W_DELAY-1:0] hsync_delay;
	} frame_cfg_t;

	typedef struct packed {
		act_type_e act_type;
		logic [4:0] bias_shift;		// Applied after scaling
		logic [2:0] act_shift;		// Applied after bias
	} layer_cfg_t;

	typedef struct packed {
		logic [W_SIZE-1:0] row;
		logic [W_SIZE-1:0] col;
		logic              valid;
	} scan_pos_t;

	// Tap 0 top-left, row-major
	typedef struct packed {
		logic [N_TAPS-1:0][PIX_BITS-1:0] tap;
	} window_t;

	// First layer channels 0..3
	localparam logic signed [WGT_BITS-1:0] KERN_WEIGHTS [N_KERN][N_TAPS] = '{
		'{-8'sd114, -8'sd105, -8'sd41,  8'sd127, -8'sd93, -8'sd51, -8'sd27, -8'sd1,   8'sd113},
		'{ 8'sd69,  -8'sd75,  -8'sd47,  8'sd19, -8'sd128,  8'sd95, -8'sd35,  8'sd121, 8'sd8},
		'{ 8'sd13,  -8'sd12,  -8'sd1,  -8'sd15,  8'sd127, -8'sd16, -8'sd4,  -8'sd19,  8'sd1},
		'{ 8'sd69,  -8'sd121, -8'sd21, -8'sd128, 8'sd32,   8'sd90,  8'sd48,  8'sd52, -8'sd45}
	};

	localparam logic [PARAM_BITS-1:0] KERN_SCALE [N_KERN] = '{16'd95, 16'd103, 16'd364, 16'd170};

	localparam logic signed [PARAM_BITS-1:0] KERN_BIAS [N_KERN] = '{
		-16'sd18620, 16'sd8066, 16'sd370, -16'sd506
	};

endpackage

/* ahb_cfg_regs.sv */
`timescale 1ns/1ps

module ahb_cfg_regs
	import cnn_pkg::*;
#(
	parameter int IMG_ADDR_W     = 14,
	parameter int WIDTH          = 128,
	parameter int HEIGHT         = 128,
	parameter int START_UP_DELAY = 200,
	parameter int HSYNC_DELAY    = 160
) (
	input  logic                     HCLK,
	input  logic                     HRESETn,
	input  logic                     HSEL_i,
	input  logic                     HREADY_i,
	input  htrans_e                  HTRANS_i,
	input  logic [AHB_ADDR_BITS-1:0] HADDR_i,
	input  logic                     HWRITE_i,
	input  logic [AHB_DATA_BITS-1:0] HWDATA_i,
	input  logic                     frame_end_i,
	output logic [AHB_DATA_BITS-1:0] HRDATA_o,
	output logic                     HREADY_o,
	output logic                     HRESP_o,
	output frame_cfg_t               frame_cfg_o,
	output layer_cfg_t               layer_cfg_o,
	output logic                     start_o,
	output logic                     pix_we_o,
	output logic [IMG_ADDR_W-1:0]    pix_addr_o,
	output logic [PIX_BITS-1:0]      pix_data_o
);
	logic                  acc_take;		// Valid address phase
	logic                  wr_q;			// Write data phase pending
	logic                  img_sel_q;
	reg_idx_e              reg_idx_q;
	logic [IMG_ADDR_W-1:0] pix_addr_q;
	logic                  cfg_wr;
	logic                  start_wr;
	logic                  done_q;
	frame_cfg_t            cfg_q;
	layer_cfg_t            lyr_q;

	// --------------------------------------------------------------------
	// Address phase
	// --------------------------------------------------------------------
	assign acc_take = HSEL_i && HREADY_i && (HTRANS_i == NONSEQ || HTRANS_i == SEQ);

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			wr_q      <= 1'b0;
			img_sel_q <= 1'b0;
			reg_idx_q <= REG_WIDTH_HEIGHT;
		end else if (acc_take) begin
			wr_q      <= HWRITE_i;
			img_sel_q <= HADDR_i[IMG_SEL_BIT];
			reg_idx_q <= reg_idx_e'(HADDR_i[IMG_SEL_BIT-1:REG_IDX_LSB]);
		end else begin
			wr_q <= 1'b0;					// Idle or busy beat
		end
	end

	always_ff @(posedge HCLK) begin
		if (acc_take) begin
			pix_addr_q <= HADDR_i[REG_IDX_LSB +: IMG_ADDR_W];	// Pixel index
		end
	end

	// --------------------------------------------------------------------
	// Data phase
	// --------------------------------------------------------------------
	assign cfg_wr   = wr_q && !img_sel_q;
	assign start_wr = cfg_wr && (reg_idx_q == REG_START) && HWDATA_i[0];

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			cfg_q.width          <= W_SIZE'(WIDTH);
			cfg_q.height         <= W_SIZE'(HEIGHT);
			cfg_q.start_up_delay <= W_DELAY'(START_UP_DELAY);
			cfg_q.hsync_delay    <= W_DELAY'(HSYNC_DELAY);
			lyr_q.act_type       <= ACT_RELU;
			lyr_q.bias_shift     <= 5'd9;
			lyr_q.act_shift      <= 3'd7;
		end else if (cfg_wr) begin
			case (reg_idx_q)
				REG_WIDTH_HEIGHT: begin
					cfg_q.width  <= HWDATA_i[W_SIZE-1:0];
					cfg_q.height <= HWDATA_i[16 +: W_SIZE];
				end
				REG_DELAYS: begin
					cfg_q.start_up_delay <= HWDATA_i[W_DELAY-1:0];
					cfg_q.hsync_delay    <= HWDATA_i[W_DELAY +: W_DELAY];
				end
				REG_LAYER_CFG: begin
					lyr_q.act_type   <= act_type_e'(HWDATA_i[3]);
					lyr_q.bias_shift <= HWDATA_i[12:8];
					lyr_q.act_shift  <= HWDATA_i[15:13];
				end
				default: ;						// Start handled below
			endcase
		end
	end

	// Start pulse and done flag
	// Start wins over a coincident frame end
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			start_o <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			start_o <= start_wr;
			if (start_wr) begin
				done_q <= 1'b0;
			end else if (frame_end_i) begin
				done_q <= 1'b1;
			end
		end
	end

	// Read-back mux
	always_comb begin
		HRDATA_o = '0;
		if (!img_sel_q) begin
			case (reg_idx_q)
				REG_WIDTH_HEIGHT: HRDATA_o = {4'b0, cfg_q.height, 4'b0, cfg_q.width};
				REG_DELAYS:       HRDATA_o = {8'b0, cfg_q.hsync_delay, cfg_q.start_up_delay};
				REG_LAYER_CFG:    HRDATA_o = {16'b0, lyr_q.act_shift, lyr_q.bias_shift,
											  4'b0, lyr_q.act_type, 3'b0};
				REG_DONE:         HRDATA_o = {31'b0, done_q};
				default:          HRDATA_o = '0;
			endcase
		end
	end

	assign HREADY_o    = 1'b1;				// Zero wait states
	assign HRESP_o     = HRESP_OKAY;
	assign frame_cfg_o = cfg_q;
	assign layer_cfg_o = lyr_q;
	assign pix_we_o    = wr_q && img_sel_q;
	assign pix_addr_o  = pix_addr_q;
	assign pix_data_o  = HWDATA_i[PIX_BITS-1:0];

endmodule

/* frame_scanner.sv */
`timescale 1ns/1ps

module frame_scanner
	import cnn_pkg::*;
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  frame_cfg_t frame_cfg_i,
	input  logic       start_i,
	output scan_pos_t  pos_o,
	output logic       frame_end_o
);
	scan_state_e        state;
	logic [W_DELAY-1:0] dly_cnt;		// Shared by start-up and hsync
	logic [W_DELAY-1:0] dly_lim;
	logic [W_SIZE-1:0]  row;
	logic [W_SIZE-1:0]  col;
	logic               last_col;
	logic               last_row;
	logic               dly_done;

	assign last_col = (col == frame_cfg_i.width - 1'b1);
	assign last_row = (row == frame_cfg_i.height - 1'b1);
	assign dly_lim  = (state == SCAN_HSYNC) ? frame_cfg_i.hsync_delay
											 : frame_cfg_i.start_up_delay;
	assign dly_done = (dly_cnt == dly_lim - 1'b1);

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state   <= SCAN_IDLE;
			dly_cnt <= '0;
			row     <= '0;
			col     <= '0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (start_i) begin
						row     <= '0;
						col     <= '0;
						dly_cnt <= '0;
						// Zero delay skips straight to the first row
						state   <= (frame_cfg_i.start_up_delay == '0) ? SCAN_ROW : SCAN_STARTUP;
					end
				end
				SCAN_STARTUP, SCAN_HSYNC: begin
					dly_cnt <= dly_cnt + 1'b1;
					if (dly_done) begin
						dly_cnt <= '0;
						state   <= SCAN_ROW;
					end
				end
				SCAN_ROW: begin
					if (last_col) begin
						col <= '0;
						if (last_row) begin
							state <= SCAN_IDLE;		// Frame complete
						end else begin
							row   <= row + 1'b1;
							state <= (frame_cfg_i.hsync_delay == '0) ? SCAN_ROW : SCAN_HSYNC;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	assign pos_o.row   = row;
	assign pos_o.col   = col;
	assign pos_o.valid = (state == SCAN_ROW);			// One position per cycle
	assign frame_end_o = pos_o.valid && last_col && last_row;

endmodule

/* window_gen.sv */
`timescale 1ns/1ps

module window_gen
	import cnn_pkg::*;
#(
	parameter int IMG_ADDR_W = 14
) (
	input  logic                  HCLK,
	input  logic                  HRESETn,
	input  logic [W_SIZE-1:0]     width_i,
	input  logic [W_SIZE-1:0]     height_i,
	input  logic                  pix_we_i,
	input  logic [IMG_ADDR_W-1:0] pix_addr_i,
	input  logic [PIX_BITS-1:0]   pix_data_i,
	input  scan_pos_t             pos_i,
	output window_t               win_o,
	output logic                  win_valid_o
);
	logic [PIX_BITS-1:0]   img_mem [2**IMG_ADDR_W];	// row * width + col
	logic [2*W_SIZE-1:0]   lin;						// Centre pixel index
	logic [IMG_ADDR_W-1:0] row_base [3];			// Above, centre, below
	logic [2:0]            row_out;					// Row outside frame
	logic [2:0]            col_out;					// Column outside frame
	window_t               win_d;

	// Image buffer, filled over the bus
	always_ff @(posedge HCLK) begin
		if (pix_we_i) begin
			img_mem[pix_addr_i] <= pix_data_i;
		end
	end

	assign lin         = pos_i.row * width_i + pos_i.col;
	assign row_base[0] = IMG_ADDR_W'(lin - width_i);	// Wraps on the top row and gets masked
	assign row_base[1] = IMG_ADDR_W'(lin);
	assign row_base[2] = IMG_ADDR_W'(lin + width_i);

	// Border flags for zero padding
	assign row_out = {pos_i.row == height_i - 1'b1, 1'b0, pos_i.row == '0};
	assign col_out = {pos_i.col == width_i - 1'b1, 1'b0, pos_i.col == '0};

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				win_d.tap[r*3+c] = (row_out[r] || col_out[c]) ? '0 :
					img_mem[row_base[r] + IMG_ADDR_W'(c) - IMG_ADDR_W'(1)];
			end
		end
	end

	always_ff @(posedge HCLK) begin
		win_o <= win_d;
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			win_valid_o <= 1'b0;
		end else begin
			win_valid_o <= pos_i.valid;		// One cycle behind position
		end
	end

endmodule

/* conv_kernel.sv */
`timescale 1ns/1ps

module conv_kernel
	import cnn_pkg::*;
#(
	parameter int KERN_IDX = 0
) (
	input  logic                HCLK,
	input  logic                HRESETn,
	input  layer_cfg_t          layer_cfg_i,
	input  window_t             win_i,
	input  logic                valid_i,
	output logic [PIX_BITS-1:0] pix_o,
	output logic                valid_o
);
	localparam int PROD_BITS = PIX_BITS + 1 + WGT_BITS;		// Unsigned pixel as signed
	localparam int POST_BITS = ACC_BITS + PARAM_BITS + 2;	// Scale product plus bias

	logic signed [PROD_BITS-1:0] prod_q [N_TAPS];
	logic signed [ACC_BITS-1:0]  sum_d;
	logic signed [ACC_BITS-1:0]  sum_q;
	logic signed [POST_BITS-1:0] scaled;
	logic signed [POST_BITS-1:0] shifted;
	logic signed [POST_BITS-1:0] biased;
	logic signed [POST_BITS-1:0] act;
	logic [PIX_BITS-1:0]         clip;
	logic [1:0]                  vld_q;		// Stage 1 and 2 valids

	// --------------------------------------------------------------------
	// Stage 1 products, stage 2 tap sum
	// --------------------------------------------------------------------
	always_ff @(posedge HCLK) begin
		for (int i = 0; i < N_TAPS; i++) begin
			prod_q[i] <= $signed({1'b0, win_i.tap[i]}) * KERN_WEIGHTS[KERN_IDX][i];
		end
	end

	always_comb begin
		sum_d = '0;
		for (int i = 0; i < N_TAPS; i++) begin
			sum_d = sum_d + prod_q[i];
		end
	end

	always_ff @(posedge HCLK) begin
		sum_q <= sum_d;
	end

	// --------------------------------------------------------------------
	// Stage 3 scale, bias, activation
	// --------------------------------------------------------------------
	always_comb begin
		scaled  = sum_q * $signed({1'b0, KERN_SCALE[KERN_IDX]});
		shifted = scaled >>> layer_cfg_i.bias_shift;
		biased  = shifted + KERN_BIAS[KERN_IDX];
		act     = biased >>> layer_cfg_i.act_shift;
		if (layer_cfg_i.act_type == ACT_RELU) begin
			if (act < 0)           clip = '0;
			else if (act > 255)    clip = 8'hFF;
			else                   clip = act[PIX_BITS-1:0];
		end else begin
			if (act < -128)        clip = 8'h80;		// Two's complement limits
			else if (act > 127)    clip = 8'h7F;
			else                   clip = act[PIX_BITS-1:0];
		end
	end

	always_ff @(posedge HCLK) begin
		pix_o <= clip;
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			vld_q   <= '0;
			valid_o <= 1'b0;
		end else begin
			vld_q   <= {vld_q[0], valid_i};
			valid_o <= vld_q[1];
		end
	end

endmodule

/* cnn_accel.sv */
`timescale 1ns/1ps

module cnn_accel
	import cnn_pkg::*;
#(
	parameter int MAX_WIDTH      = 128,
	parameter int MAX_HEIGHT     = 128,
	parameter int WIDTH          = 128,
	parameter int HEIGHT         = 128,
	parameter int START_UP_DELAY = 200,
	parameter int HSYNC_DELAY    = 160
) (
	input  logic                         HCLK,
	input  logic                         HRESETn,
	input  logic                         HSEL_i,
	input  logic                         HREADY_i,
	input  htrans_e                      HTRANS_i,
	input  logic [AHB_ADDR_BITS-1:0]     HADDR_i,
	input  logic                         HWRITE_i,
	input  logic [AHB_DATA_BITS-1:0]     HWDATA_i,
	output logic [AHB_DATA_BITS-1:0]     HRDATA_o,
	output logic                         HREADY_o,
	output logic                         HRESP_o,
	output logic [N_KERN*PIX_BITS-1:0]   out_pixel_o,	// Kernel k in byte k
	output logic                         out_valid_o
);
	localparam int IMG_ADDR_W = $clog2(MAX_WIDTH * MAX_HEIGHT);

	frame_cfg_t                      frame_cfg;
	layer_cfg_t                      layer_cfg;
	logic                            start;
	logic                            frame_end;
	logic                            pix_we;
	logic [IMG_ADDR_W-1:0]           pix_addr;
	logic [PIX_BITS-1:0]             pix_data;
	scan_pos_t                       scan_pos;
	window_t                         win;
	logic                            win_valid;
	logic [N_KERN-1:0][PIX_BITS-1:0] kern_pix;
	logic [N_KERN-1:0]               kern_valid;

	ahb_cfg_regs #(
		.IMG_ADDR_W     (IMG_ADDR_W),
		.WIDTH          (WIDTH),
		.HEIGHT         (HEIGHT),
		.START_UP_DELAY (START_UP_DELAY),
		.HSYNC_DELAY    (HSYNC_DELAY)
	) u_regs (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.HSEL_i      (HSEL_i),
		.HREADY_i    (HREADY_i),
		.HTRANS_i    (HTRANS_i),
		.HADDR_i     (HADDR_i),
		.HWRITE_i    (HWRITE_i),
		.HWDATA_i    (HWDATA_i),
		.frame_end_i (frame_end),
		.HRDATA_o    (HRDATA_o),
		.HREADY_o    (HREADY_o),
		.HRESP_o     (HRESP_o),
		.frame_cfg_o (frame_cfg),
		.layer_cfg_o (layer_cfg),
		.start_o     (start),
		.pix_we_o    (pix_we),
		.pix_addr_o  (pix_addr),
		.pix_data_o  (pix_data)
	);

	frame_scanner u_scan (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.frame_cfg_i (frame_cfg),
		.start_i     (start),
		.pos_o       (scan_pos),
		.frame_end_o (frame_end)
	);

	window_gen #(
		.IMG_ADDR_W (IMG_ADDR_W)
	) u_win (
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.width_i     (frame_cfg.width),
		.height_i    (frame_cfg.height),
		.pix_we_i    (pix_we),
		.pix_addr_i  (pix_addr),
		.pix_data_i  (pix_data),
		.pos_i       (scan_pos),
		.win_o       (win),
		.win_valid_o (win_valid)
	);

	// Same window into every channel
	for (genvar k = 0; k < N_KERN; k++) begin : g_kern
		conv_kernel #(
			.KERN_IDX (k)
		) u_kern (
			.HCLK        (HCLK),
			.HRESETn     (HRESETn),
			.layer_cfg_i (layer_cfg),
			.win_i       (win),
			.valid_i     (win_valid),
			.pix_o       (kern_pix[k]),
			.valid_o     (kern_valid[k])
		);
	end

	assign out_pixel_o = kern_pix;
	assign out_valid_o = kern_valid[0];		// All kernels in lockstep

endmodule

/* tb_cnn_accel.sv */
`timescale 1ns/1ps

module tb_cnn_accel
	import cnn_pkg::*;
();
	localparam int N_TESTS = 3;
	localparam int DRAIN   = 16;			// Idle cycles after last beat

	typedef struct packed {
		logic [W_SIZE-1:0]  width;
		logic [W_SIZE-1:0]  height;
		logic [W_DELAY-1:0] start_up_delay;
		logic [W_DELAY-1:0] hsync_delay;
		act_type_e          act_type;
		logic [4:0]         bias_shift;
		logic [2:0]         act_shift;
		logic               mid_start;		// Extra start while busy
	} test_row_t;

	// width, height, start-up, hsync, activation, bias shift, act shift, mid start
	localparam test_row_t TESTS [N_TESTS] = '{
		'{12'd8, 12'd8, 12'd20, 12'd6, ACT_RELU,   5'd9, 3'd7, 1'b0},
		'{12'd5, 12'd4, 12'd12, 12'd3, ACT_LINEAR, 5'd6, 3'd2, 1'b0},
		'{12'd6, 12'd5, 12'd0,  12'd0, ACT_RELU,   5'd8, 3'd5, 1'b1}
	};

	logic        HCLK = 1'b0;
	logic        HRESETn;
	logic        HSEL_i;
	logic        HREADY_i;
	htrans_e     HTRANS_i;
	logic [31:0] HADDR_i;
	logic        HWRITE_i;
	logic [31:0] HWDATA_i;
	logic [31:0] HRDATA_o;
	logic        HREADY_o;
	logic        HRESP_o;
	logic [31:0] out_pixel_o;
	logic        out_valid_o;

	logic [31:0] lfsr = 32'h947e_0ac4;
	logic [7:0]  img [256];					// Model copy of the image buffer
	logic [31:0] exp_q [$];					// Predicted pixels in scan order
	int          cycle = 0;
	int          limit;
	int          data_cyc;					// Cycle of the last write data phase
	int          first_cyc;
	int          beats;
	int          checks = 0;
	int          errors = 0;

	cnn_accel #(
		.MAX_WIDTH      (16),
		.MAX_HEIGHT     (16),
		.WIDTH          (8),
		.HEIGHT         (8),
		.START_UP_DELAY (20),
		.HSYNC_DELAY    (6)
	) UUT (.*);

	always #4 HCLK = ~HCLK;					// 8 ns period

	// Cycle count and run limit
	always @(posedge HCLK) begin
		cycle <= cycle + 1;
		if (cycle > limit) begin
			$display("Timeout after %0d cycles, the DUT stopped producing output", cycle);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------
	// Bus access over address phase then data phase
	// ------------------------------------------------------------------
	task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
		@(posedge HCLK);
		#1;
		HSEL_i   = 1'b1;
		HTRANS_i = NONSEQ;
		HADDR_i  = addr;
		HWRITE_i = 1'b1;
		@(posedge HCLK);
		#1;
		HTRANS_i = IDLE;				// Data phase
		HSEL_i   = 1'b0;
		HWDATA_i = data;
		data_cyc = cycle;
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
		@(posedge HCLK);
		#1;
		HSEL_i   = 1'b1;
		HTRANS_i = NONSEQ;
		HADDR_i  = addr;
		HWRITE_i = 1'b0;
		@(posedge HCLK);
		#1;
		HTRANS_i = IDLE;
		HSEL_i   = 1'b0;
		data     = HRDATA_o;				// Combinational in data phase
		check_val("HREADY_o", {31'b0, HREADY_o}, 32'd1);
		check_val("HRESP_o", {31'b0, HRESP_o}, 32'd0);	// AHB OKAY
	endtask

	function automatic logic [31:0] reg_addr(input int idx);
		return 32'(idx) << REG_IDX_LSB;
	endfunction

	function automatic logic [31:0] pix_addr(input int idx);
		return (32'd1 << IMG_SEL_BIT) | (32'(idx) << REG_IDX_LSB);
	endfunction

	// Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
	function automatic logic [7:0] next_byte();
		logic       fb;
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			b    = {b[6:0], fb};
		end
		return b;
	endfunction

	// ------------------------------------------------------------------
	// Reference model for all four channels at one scan position
	// ------------------------------------------------------------------
	function automatic logic [31:0] expected_pixel(input int r, input int c,
												   input test_row_t row);
		logic [31:0] res;
		logic [7:0]  px;
		longint      acc;
		longint      v;
		int          rr;
		int          cc;
		int          p;
		res = '0;
		for (int k = 0; k < N_KERN; k++) begin
			acc = 0;
			for (int i = 0; i < N_TAPS; i++) begin
				rr = r + i / 3 - 1;
				cc = c + i % 3 - 1;
				if (rr < 0 || cc < 0 || rr >= int'(row.height) || cc >= int'(row.width))
					p = 0;						// Zero padding
				else
					p = int'(img[rr * int'(row.width) + cc]);
				acc += longint'(p) * longint'(KERN_WEIGHTS[k][i]);
			end
			v = (acc * longint'(KERN_SCALE[k])) >>> row.bias_shift;
			v = (v + longint'(KERN_BIAS[k])) >>> row.act_shift;
			if (row.act_type == ACT_RELU)
				px = (v < 0) ? 8'h00 : (v > 255) ? 8'hFF : v[7:0];
			else
				px = (v < -128) ? 8'h80 : (v > 127) ? 8'h7F : v[7:0];
			res[k*8 +: 8] = px;
		end
		return res;
	endfunction

	function automatic int run_limit();
		int n = 300;						// Reset and register test
		for (int t = 0; t < N_TESTS; t++) begin
			n += 3 * int'(TESTS[t].width) * int'(TESTS[t].height);	// Load and scan
			n += int'(TESTS[t].start_up_delay);
			n += int'(TESTS[t].hsync_delay) * int'(TESTS[t].height);
			n += 100 + DRAIN;				// Config writes, reads, pipeline
		end
		return n;
	endfunction

	// Collector comparing every output beat
	always @(negedge HCLK) begin
		if (HRESETn && out_valid_o) begin
			if (first_cyc < 0) first_cyc = cycle;
			beats++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("Output beat at cycle %0d with no pixel left to expect", cycle);
			end else begin
				check_val("out_pixel_o", out_pixel_o, exp_q.pop_front());
			end
		end
	end

	task automatic run_frame(input int t);
		test_row_t   row;
		logic [31:0] rd;
		logic [7:0]  b;
		int          npix;
		int          err0;
		int          start_cyc;
		row  = TESTS[t];
		err0 = errors;
		npix = int'(row.width) * int'(row.height);
		write_word(reg_addr(REG_WIDTH_HEIGHT), {4'b0, row.height, 4'b0, row.width});
		write_word(reg_addr(REG_DELAYS), {8'b0, row.hsync_delay, row.start_up_delay});
		write_word(reg_addr(REG_LAYER_CFG),
				   {16'b0, row.act_shift, row.bias_shift, 4'b0, row.act_type, 3'b0});
		for (int i = 0; i < npix; i++) begin
			b      = next_byte();
			img[i] = b;
			write_word(pix_addr(i), {24'b0, b});
		end
		exp_q.delete();
		for (int r = 0; r < int'(row.height); r++)
			for (int c = 0; c < int'(row.width); c++)
				exp_q.push_back(expected_pixel(r, c, row));
		beats     = 0;
		first_cyc = -1;
		write_word(reg_addr(REG_START), 32'd1);
		start_cyc = data_cyc;
		read_word(reg_addr(REG_DONE), rd);
		check_val("HRDATA_o done", rd, 32'd0);		// Cleared by start
		if (row.mid_start) begin
			while (beats == 0) @(posedge HCLK);
			write_word(reg_addr(REG_START), 32'd1);	// Ignored while the scanner is busy
		end
		while (beats < npix) @(posedge HCLK);
		read_word(reg_addr(REG_DONE), rd);
		check_val("HRDATA_o done", rd, 32'd1);
		repeat (DRAIN) @(posedge HCLK);
		check_val("out_valid_o beats", 32'(beats), 32'(npix));
		check_val("pixels left", 32'(exp_q.size()), 32'd0);
		if (first_cyc - start_cyc < int'(row.start_up_delay) + 4) begin
			errors++;
			$display("First output came %0d cycles after start, before the start-up delay",
					 first_cyc - start_cyc);
		end
		$display("Test %0d frame %0dx%0d %s: %0d errors", t + 1, row.width, row.height,
				 row.act_type.name(), errors - err0);
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		int          err0;
		HRESETn  = 1'b0;
		HSEL_i   = 1'b0;
		HREADY_i = 1'b1;
		HTRANS_i = IDLE;
		HADDR_i  = '0;
		HWRITE_i = 1'b0;
		HWDATA_i = '0;
		limit    = run_limit();
		repeat (2) @(posedge HCLK);
		#1;
		HRESETn = 1'b1;

		// Reset defaults then written fields
		err0 = errors;
		read_word(reg_addr(REG_WIDTH_HEIGHT), rd);
		check_val("HRDATA_o width_height", rd, 32'h0008_0008);	// 8x8
		read_word(reg_addr(REG_DELAYS), rd);
		check_val("HRDATA_o delays", rd, (32'd6 << 12) | 32'd20);
		read_word(reg_addr(REG_LAYER_CFG), rd);
		check_val("HRDATA_o layer_cfg", rd, (32'd7 << 13) | (32'd9 << 8));	// ReLU
		read_word(reg_addr(REG_DONE), rd);
		check_val("HRDATA_o done", rd, 32'd0);
		write_word(reg_addr(REG_WIDTH_HEIGHT), 32'hFABC_F123);	// Upper nibbles dropped
		read_word(reg_addr(REG_WIDTH_HEIGHT), rd);
		check_val("HRDATA_o width_height", rd, 32'h0ABC_0123);
		write_word(reg_addr(REG_DELAYS), 32'hFF45_6789);
		read_word(reg_addr(REG_DELAYS), rd);
		check_val("HRDATA_o delays", rd, 32'h0045_6789);
		write_word(reg_addr(REG_LAYER_CFG), 32'hFFFF_FFFF);
		read_word(reg_addr(REG_LAYER_CFG), rd);
		check_val("HRDATA_o layer_cfg", rd, 32'h0000_FF08);
		write_word(reg_addr(REG_START), 32'd0);				// Bit 0 clear so no start
		read_word(reg_addr(REG_START), rd);
		check_val("HRDATA_o start", rd, 32'd0);
		write_word(reg_addr(7), 32'hFFFF_FFFF);
		read_word(reg_addr(7), rd);
		check_val("HRDATA_o unused", rd, 32'd0);
		$display("Test 0 register read-back: %0d errors", errors - err0);

		for (int t = 0; t < N_TESTS; t++) begin
			run_frame(t);
		end

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* compile.f */
cnn_pkg.sv
ahb_cfg_regs.sv
frame_scanner.sv
window_gen.sv
conv_kernel.sv
cnn_accel.sv
tb_cnn_accel.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cnn_accel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_cnn_accel -o sim_cnn
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_cnn)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
